/* edExec.f */
+incdir+hw
hw/edExecPkg.sv
hw/edDecoder.sv
hw/wideAlu.sv
hw/regPairFile.sv
hw/opFetch.sv
hw/dataMover.sv
hw/memArbiter.sv
hw/edCore.sv
hw/edExecTop.sv
verif/edExec_checker.sv
verif/edExecTb.sv

/* run_edExec.sh */
#!/bin/sh
# Compile and run the edExec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module edExecTb -f edExec.f -o edExecSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/edExecSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Testbench passed" sim.log; then
    exit 0
fi
exit 1

/* verif/edExecTb.sv */
// Testbench with APB memory model, directed ED group tests and watchdog
`include "edExec_defines.svh"
module edExecTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ClkPeriod = 40;
    localparam int StepLimit = 200;
    // Instructions issued over all tests together
    localparam int RunInstr = 81;

    logic        clk = 1'b0;
    logic        rstN;
    logic        run;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic [7:0]  flags;
    logic        trap;
    logic        busy;

    logic [7:0]  mem [65536];
    logic [7:0]  goldMem [65536];
    logic [15:0] vals [4];
    logic [15:0] codePtr;
    bit          randomWaits;
    int          writeCount;
    int          errorCount;
    int          checkCount;

    edExecTop uut (.*);

    always #(ClkPeriod / 2) clk = ~clk;

    // APB memory, with 0 to 2 wait cycles per transfer when enabled
    initial begin
        int waitLeft;
        pready = 1'b0;
        prdata = 8'h00;
        writeCount = 0;
        waitLeft = 0;
        forever begin
            @(posedge clk);
            #1;
            pready = 1'b0;
            if (psel && penable) begin
                if (waitLeft == 0) begin
                    pready = 1'b1;
                    if (pwrite) begin
                        mem[paddr] = pwdata;
                        writeCount++;
                    end else begin
                        prdata = mem[paddr];
                    end
                end else begin
                    waitLeft--;
                end
            end else if (psel) begin
                waitLeft = randomWaits ? $urandom_range(2, 0) : 0;
            end
        end
    end

    initial begin
        #(RunInstr * StepLimit * ClkPeriod);
        $display("Timeout: the run did not finish within %0d cycles", RunInstr * StepLimit);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [7:0] fillByte(input logic [15:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'hA5;
    endfunction

    function automatic logic [15:0] memWord(input logic [15:0] a);
        return {mem[a + 16'd1], mem[a]};
    endfunction

    // Expected {flags, result} of ADC or SBC, worked out in integer arithmetic
    function automatic logic [23:0] refArith(input logic [15:0] a, input logic [15:0] b,
                                            input logic carry, input logic sub);
        int full;
        int half;
        int sgn;
        logic [15:0] res;
        logic h;
        logic c;
        logic v;
        if (sub) begin
            full = int'(a) - int'(b) - int'(carry);
            half = int'(a[11:0]) - int'(b[11:0]) - int'(carry);
            sgn = int'($signed(a)) - int'($signed(b)) - int'(carry);
        end else begin
            full = int'(a) + int'(b) + int'(carry);
            half = int'(a[11:0]) + int'(b[11:0]) + int'(carry);
            sgn = int'($signed(a)) + int'($signed(b)) + int'(carry);
        end
        res = full[15:0];
        c = sub ? (full < 0) : (full > 65535);
        h = sub ? (half < 0) : (half > 4095);
        v = (sgn > 32767) || (sgn < -32768);
        return {res[15], res == 16'd0, 1'b0, h, 1'b0, v, sub, c, res};
    endfunction

    task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic resetDut();
        @(posedge clk);
        #1;
        run = 1'b0;
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
    endtask

    task automatic fillMem();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fillByte(16'(a));
        end
        codePtr = `ResetPc;
    endtask

    task automatic putWord(input logic [15:0] a, input logic [15:0] w);
        mem[a] = w[7:0];
        mem[a + 16'd1] = w[15:8];
    endtask

    task automatic emitOp(input logic [7:0] op);
        mem[codePtr] = `EdPrefix;
        mem[codePtr + 16'd1] = op;
        codePtr += 16'd2;
    endtask

    task automatic emitOpNn(input logic [7:0] op, input logic [15:0] nn);
        emitOp(op);
        putWord(codePtr, nn);
        codePtr += 16'd2;
    endtask

    // One instruction: pulse run, then wait for idle or trap
    task automatic stepInstr();
        int cycles;
        cycles = 0;
        run = 1'b1;
        @(posedge clk);
        #1 run = 1'b0;
        while (busy && !trap && cycles < StepLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (cycles < StepLimit) else begin
            errorCount++;
            $display("** Error at %0t: instruction did not finish in %0d cycles", $time, cycles);
        end
    endtask

    task automatic loadStoreTest();
        resetDut();
        fillMem();
        for (int p = 0; p < 4; p++) begin
            vals[p] = 16'($urandom);
            putWord(16'h8000 + 16'(2 * p), vals[p]);
            emitOpNn(8'h4B | {2'b00, 2'(p), 4'h0}, 16'h8000 + 16'(2 * p));
        end
        for (int p = 0; p < 4; p++) begin
            emitOpNn(8'h43 | {2'b00, 2'(p), 4'h0}, 16'h9000 + 16'(2 * p));
        end
        repeat (8) stepInstr();
        for (int p = 0; p < 4; p++) begin
            checkVal($sformatf("low byte of pair %0d", p), 16'(mem[16'h9000 + 16'(2 * p)]),
                     16'(vals[p][7:0]));
            checkVal($sformatf("high byte of pair %0d", p), 16'(mem[16'h9001 + 16'(2 * p)]),
                     16'(vals[p][15:8]));
        end
    endtask

    // Second op in a row picks up the carry of the first
    task automatic arithCase(input int pair, input bit sub, input logic [15:0] hlVal,
                             input logic [15:0] rrVal);
        logic [7:0]  opBits;
        logic [15:0] rrUse;
        logic [15:0] rrNext;
        logic [23:0] first;
        logic [23:0] second;
        opBits = (sub ? 8'h42 : 8'h4A) | {2'b00, 2'(pair), 4'h0};
        rrUse = (pair == 2) ? hlVal : rrVal;
        resetDut();
        fillMem();
        putWord(16'h8000, hlVal);
        putWord(16'h8002, rrUse);
        emitOp(8'h62);
        emitOpNn(8'h4B | {2'b00, 2'(pair), 4'h0}, 16'h8002);
        emitOpNn(8'h6B, 16'h8000);
        emitOp(opBits);
        emitOpNn(8'h63, 16'h9000);
        emitOp(opBits);
        emitOpNn(8'h63, 16'h9002);
        first = refArith(hlVal, rrUse, 1'b0, sub);
        rrNext = (pair == 2) ? first[15:0] : rrUse;
        second = refArith(first[15:0], rrNext, first[16], sub);
        repeat (5) stepInstr();
        checkVal("flags", 16'(flags), 16'(first[23:16]));
        checkVal("stored HL", memWord(16'h9000), first[15:0]);
        repeat (2) stepInstr();
        checkVal("flags", 16'(flags), 16'(second[23:16]));
        checkVal("stored HL", memWord(16'h9002), second[15:0]);
        checkVal("trap", 16'(trap), 16'd0);
    endtask

    task automatic trapCase(input logic [7:0] first, input logic [7:0] second);
        int writesBefore;
        resetDut();
        fillMem();
        mem[0] = first;
        mem[1] = second;
        codePtr = 16'd2;
        emitOpNn(8'h73, 16'h9000);
        writesBefore = writeCount;
        stepInstr();
        checkVal("trap", 16'(trap), 16'd1);
        stepInstr();
        repeat (20) @(posedge clk);
        #1;
        checkVal("busy", 16'(busy), 16'd0);
        checkVal("memory writes", 16'(writeCount - writesBefore), 16'd0);
    endtask

    task automatic mixedRun();
        resetDut();
        fillMem();
        for (int p = 0; p < 4; p++) begin
            putWord(16'h8000 + 16'(2 * p), vals[p]);
            emitOpNn(8'h4B | {2'b00, 2'(p), 4'h0}, 16'h8000 + 16'(2 * p));
        end
        emitOp(8'h4A);
        emitOpNn(8'h63, 16'h9000);
        emitOp(8'h52);
        emitOpNn(8'h63, 16'h9002);
        emitOp(8'h7A);
        emitOpNn(8'h63, 16'h9004);
        repeat (10) stepInstr();
    endtask

    task automatic waitStressTest();
        int mismatches;
        logic [7:0] goldFlags;
        logic [23:0] adcBc;
        logic [23:0] sbcDe;
        logic [23:0] adcSp;
        for (int p = 0; p < 4; p++) begin
            vals[p] = 16'($urandom);
        end
        // HL starts as the loaded word, carry starts clear after reset
        adcBc = refArith(vals[2], vals[0], 1'b0, 1'b0);
        sbcDe = refArith(adcBc[15:0], vals[1], adcBc[16], 1'b1);
        adcSp = refArith(sbcDe[15:0], vals[3], sbcDe[16], 1'b0);
        randomWaits = 1'b0;
        mixedRun();
        checkVal("stored HL after ADC HL,BC", memWord(16'h9000), adcBc[15:0]);
        checkVal("stored HL after SBC HL,DE", memWord(16'h9002), sbcDe[15:0]);
        checkVal("stored HL after ADC HL,SP", memWord(16'h9004), adcSp[15:0]);
        checkVal("flags", 16'(flags), 16'(adcSp[23:16]));
        goldFlags = flags;
        for (int a = 0; a < 65536; a++) begin
            goldMem[a] = mem[a];
        end
        randomWaits = 1'b1;
        mixedRun();
        mismatches = 0;
        for (int a = 0; a < 65536; a++) begin
            if (mem[a] !== goldMem[a]) begin
                mismatches++;
            end
        end
        checkVal("bytes differing from zero-wait run", 16'(mismatches), 16'd0);
        checkVal("flags", 16'(flags), 16'(goldFlags));
    endtask

    initial begin
        void'($urandom(90));
        rstN = 1'b0;
        run = 1'b0;
        randomWaits = 1'b1;
        errorCount = 0;
        checkCount = 0;
        loadStoreTest();
        arithCase(1, 1'b0, 16'h1234, 16'h0FFF);
        arithCase(0, 1'b0, 16'h7FFF, 16'h0001);
        arithCase(3, 1'b0, 16'hFFFF, 16'h0001);
        arithCase(1, 1'b1, 16'h1000, 16'h2000);
        arithCase(0, 1'b1, 16'h8000, 16'h0001);
        arithCase(1, 1'b1, 16'h5555, 16'h5555);
        arithCase(2, 1'b1, 16'hA5C3, 16'h0000);
        trapCase(8'h00, 8'h63);
        trapCase(`EdPrefix, 8'h40);
        waitStressTest();
        errorCount += uut.uChecker.failCount;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verif/edExec_checker.sv */
// APB phase, APB stability and sticky trap assertions, bound to the top level
module edExecChecker (
    input logic        clk,
    input logic        rstN,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [15:0] paddr,
    input logic        pready,
    input logic        trap
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // Access phase comes exactly one cycle after setup
    setupToAccess: assert property (@(posedge clk) disable iff (!rstN)
        (psel && !penable) |=> (psel && penable))
        else begin
            $error("penable did not follow psel by one cycle");
            failCount++;
        end

    // Address and direction hold while the memory stalls
    holdDuringWait: assert property (@(posedge clk) disable iff (!rstN)
        (penable && !pready) |=> ($stable(paddr) && $stable(pwrite)))
        else begin
            $error("paddr or pwrite changed during a wait state");
            failCount++;
        end

    trapSticky: assert property (@(posedge clk) disable iff (!rstN)
        trap |=> trap)
        else begin
            $error("trap dropped without reset");
            failCount++;
        end

endmodule

// Top level carries both the APB signals and trap
bind edExecTop edExecChecker uChecker (
    .clk(clk),
    .rstN(rstN),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pready(pready),
    .trap(trap)
);

/* hw/edExecTop.sv */
// Top level joining core, fetch, data mover and APB arbiter
`include "edExec_defines.svh"
module edExecTop import edExecPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     run,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [`ApbAddrWidth-1:0] paddr,
    output logic [7:0]               pwdata,
    input  logic [7:0]               prdata,
    input  logic                     pready,
    output logic [7:0]               flags,
    output logic                     trap,
    output logic                     busy
);

    logic        fetchStart;
    logic        fetchDone;
    logic [15:0] pc;
    fetchRsp_t   fetchResult;
    logic        moveStart;
    logic        moveWrite;
    logic [15:0] moveAddr;
    logic [15:0] storeData;
    logic        moveDone;
    logic [15:0] loadData;
    memReq_t     fetchMemReq;
    memReq_t     moveMemReq;
    memRsp_t     fetchMemRsp;
    memRsp_t     moveMemRsp;

    edCore uCore (
        .clk(clk),
        .rstN(rstN),
        .run(run),
        .trap(trap),
        .busy(busy),
        .flags(flags),
        .fetchStart(fetchStart),
        .pc(pc),
        .fetchDone(fetchDone),
        .fetchRsp(fetchResult),
        .moveStart(moveStart),
        .moveWrite(moveWrite),
        .moveAddr(moveAddr),
        .storeData(storeData),
        .moveDone(moveDone),
        .loadData(loadData)
    );

    opFetch uFetch (
        .clk(clk),
        .rstN(rstN),
        .fetchStart(fetchStart),
        .pc(pc),
        .fetchDone(fetchDone),
        .rsp(fetchResult),
        .memReq(fetchMemReq),
        .memRsp(fetchMemRsp)
    );

    dataMover uMover (
        .clk(clk),
        .rstN(rstN),
        .moveStart(moveStart),
        .moveWrite(moveWrite),
        .addr(moveAddr),
        .storeData(storeData),
        .moveDone(moveDone),
        .loadData(loadData),
        .memReq(moveMemReq),
        .memRsp(moveMemRsp)
    );

    memArbiter uArbiter (
        .clk(clk),
        .rstN(rstN),
        .fetchReq(fetchMemReq),
        .moveReq(moveMemReq),
        .fetchRsp(fetchMemRsp),
        .moveRsp(moveMemRsp),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

endmodule

/* hw/edCore.sv */
// Instruction sequencer with decoder, ALU and register file
`include "edExec_defines.svh"
module edCore import edExecPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        run,
    output logic        trap,
    output logic        busy,
    output logic [7:0]  flags,
    output logic        fetchStart,
    output logic [15:0] pc,
    input  logic        fetchDone,
    input  fetchRsp_t   fetchRsp,
    output logic        moveStart,
    output logic        moveWrite,
    output logic [15:0] moveAddr,
    output logic [15:0] storeData,
    input  logic        moveDone,
    input  logic [15:0] loadData
);

    typedef enum logic [1:0] {Idle, Fetch, Exec, Move} state_e;

    state_e      state;
    edCtrl_t     ctrl;
    pair_e       rdPair;
    pair_e       wrPair;
    logic [15:0] rdData;
    logic [15:0] wrData;
    logic [15:0] hlHold;
    logic [15:0] aluResult;
    logic [7:0]  aluFlags;
    logic        wrEn;
    logic        flagWrEn;
    logic        lenOk;
    logic        fault;
    logic        isArith;

    edDecoder uDecoder (.op(fetchRsp.op), .ctrl(ctrl));

    // HL is captured while fetching so the single read port can serve rr in Exec
    assign rdPair = (state == Fetch) ? PairHl : ctrl.pair;

    wideAlu uAlu (
        .a(hlHold),
        .b(rdData),
        .carryIn(flags[0]),
        .subtract(ctrl.doSbc),
        .result(aluResult),
        .flagsOut(aluFlags)
    );

    regPairFile uRegs (
        .clk(clk),
        .rstN(rstN),
        .rdPair(rdPair),
        .rdData(rdData),
        .wrEn(wrEn),
        .wrPair(wrPair),
        .wrData(wrData),
        .flagWrEn(flagWrEn),
        .flagsIn(aluFlags),
        .flags(flags)
    );

    // Fetched length must agree with the decoded form
    assign lenOk = (fetchRsp.pcNext - pc) == (ctrl.needNn ? 16'd4 : 16'd2);
    assign fault = fetchRsp.badPrefix || !ctrl.legal || !lenOk;
    assign isArith = ctrl.doAdc || ctrl.doSbc;

    assign wrEn = ((state == Exec) && !fault && isArith) ||
                  ((state == Move) && moveDone && ctrl.doLoad);
    assign wrPair = (state == Exec) ? PairHl : ctrl.pair;
    assign wrData = (state == Exec) ? aluResult : loadData;
    assign flagWrEn = (state == Exec) && !fault && ctrl.writeFlags;

    assign fetchStart = (state == Idle) && run && !trap;
    assign moveStart = (state == Exec) && !fault && (ctrl.doStore || ctrl.doLoad);
    assign moveWrite = ctrl.doStore;
    assign moveAddr = fetchRsp.nn;
    assign storeData = rdData;
    assign busy = (state != Idle);

    always_ff @(posedge clk) begin
        if (state == Fetch) begin
            hlHold <= rdData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
            pc <= `ResetPc;
            trap <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (fetchStart) begin
                        state <= Fetch;
                    end
                end
                Fetch: begin
                    if (fetchDone) begin
                        state <= Exec;
                    end
                end
                Exec: begin
                    if (fault) begin
                        trap <= 1'b1;
                        state <= Idle;
                    end else if (moveStart) begin
                        state <= Move;
                    end else begin
                        pc <= fetchRsp.pcNext;
                        state <= Idle;
                    end
                end
                default: begin
                    if (moveDone) begin
                        pc <= fetchRsp.pcNext;
                        state <= Idle;
                    end
                end
            endcase
        end
    end

endmodule

/* hw/memArbiter.sv */
// Round-robin arbiter driving one client request at a time onto APB
`include "edExec_defines.svh"
module memArbiter import edExecPkg::*; (
    input  logic                     clk,
    input  logic                     rstN,
    input  memReq_t                  fetchReq,
    input  memReq_t                  moveReq,
    output memRsp_t                  fetchRsp,
    output memRsp_t                  moveRsp,
    output logic                     psel,
    output logic                     penable,
    output logic                     pwrite,
    output logic [`ApbAddrWidth-1:0] paddr,
    output logic [7:0]               pwdata,
    input  logic [7:0]               prdata,
    input  logic                     pready
);

    typedef enum logic [1:0] {ApbIdle, ApbSetup, ApbAccess} phase_e;

    phase_e  phase;
    logic    grantMove;
    logic    pickMove;
    memReq_t selReq;

    // On a tie the client not served last wins, grantMove keeps the last grant
    assign pickMove = moveReq.req && (!fetchReq.req || !grantMove);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= ApbIdle;
            grantMove <= 1'b0;
        end else begin
            case (phase)
                ApbIdle: begin
                    if (fetchReq.req || moveReq.req) begin
                        grantMove <= pickMove;
                        phase <= ApbSetup;
                    end
                end
                ApbSetup: phase <= ApbAccess;
                ApbAccess: begin
                    if (pready) begin
                        phase <= ApbIdle;
                    end
                end
                default: phase <= ApbIdle;
            endcase
        end
    end

    // Clients hold their request until done, so the mux stays stable
    assign selReq = grantMove ? moveReq : fetchReq;

    assign psel = (phase != ApbIdle);
    assign penable = (phase == ApbAccess);
    assign pwrite = selReq.write;
    assign paddr = selReq.addr;
    assign pwdata = selReq.wdata;

    assign fetchRsp = '{done: penable && pready && !grantMove, rdata: prdata};
    assign moveRsp = '{done: penable && pready && grantMove, rdata: prdata};

endmodule

/* hw/dataMover.sv */
// Two-byte little-endian store to or load from address nn
module dataMover import edExecPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        moveStart,
    input  logic        moveWrite,
    input  logic [15:0] addr,
    input  logic [15:0] storeData,
    output logic        moveDone,
    output logic [15:0] loadData,
    output memReq_t     memReq,
    input  memRsp_t     memRsp
);

    logic        reqOn;
    logic        highByte;
    logic        writeDir;
    logic [15:0] curAddr;
    logic [7:0]  highStore;
    logic [7:0]  wdata;
    logic        gotByte;

    assign gotByte = reqOn && memRsp.done;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqOn <= 1'b0;
            highByte <= 1'b0;
            moveDone <= 1'b0;
        end else begin
            moveDone <= 1'b0;
            if (moveStart) begin
                reqOn <= 1'b1;
                highByte <= 1'b0;
            end else if (gotByte) begin
                highByte <= 1'b1;
                if (highByte) begin
                    reqOn <= 1'b0;
                    moveDone <= 1'b1;
                end
            end
        end
    end

    // Low byte goes first at nn, high byte follows at nn+1
    always_ff @(posedge clk) begin
        if (moveStart) begin
            writeDir <= moveWrite;
            curAddr <= addr;
            wdata <= storeData[7:0];
            highStore <= storeData[15:8];
        end else if (gotByte) begin
            curAddr <= curAddr + 16'd1;
            wdata <= highStore;
            if (highByte) begin
                loadData[15:8] <= memRsp.rdata;
            end else begin
                loadData[7:0] <= memRsp.rdata;
            end
        end
    end

    assign memReq = '{req: reqOn, write: writeDir, addr: curAddr, wdata: wdata};

endmodule

/* hw/opFetch.sv */
// Instruction byte reader for prefix, opcode and optional nn operand
`include "edExec_defines.svh"
module opFetch import edExecPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      fetchStart,
    input  logic [15:0] pc,
    output logic      fetchDone,
    output fetchRsp_t rsp,
    output memReq_t   memReq,
    input  memRsp_t   memRsp
);

    logic        reqOn;
    logic [1:0]  cnt;
    logic [15:0] addr;
    logic        gotByte;
    logic        lastByte;
    opcode_u     opByte;

    assign opByte = memRsp.rdata;
    assign gotByte = reqOn && memRsp.done;

    // Length is known once the opcode byte arrives
    always_comb begin
        case (cnt)
            2'd0: lastByte = (memRsp.rdata != `EdPrefix);
            2'd1: lastByte = !((opByte.xyz.x == 2'd1) && (opByte.xyz.z == 3'd3));
            2'd2: lastByte = 1'b0;
            default: lastByte = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqOn <= 1'b0;
            cnt <= 2'd0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            if (fetchStart) begin
                reqOn <= 1'b1;
                cnt <= 2'd0;
            end else if (gotByte) begin
                cnt <= cnt + 2'd1;
                if (lastByte) begin
                    reqOn <= 1'b0;
                    fetchDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchStart) begin
            addr <= pc;
            rsp.badPrefix <= 1'b0;
        end else if (gotByte) begin
            addr <= addr + 16'd1;
            rsp.pcNext <= addr + 16'd1;
            case (cnt)
                2'd0: rsp.badPrefix <= (memRsp.rdata != `EdPrefix);
                2'd1: rsp.op <= opByte;
                2'd2: rsp.nn[7:0] <= memRsp.rdata;
                default: rsp.nn[15:8] <= memRsp.rdata;
            endcase
        end
    end

    assign memReq = '{req: reqOn, write: 1'b0, addr: addr, wdata: 8'h00};

endmodule

/* hw/regPairFile.sv */
// BC, DE, HL, SP and F registers with one read port, one write port and a flag write
module regPairFile import edExecPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  pair_e       rdPair,
    output logic [15:0] rdData,
    input  logic        wrEn,
    input  pair_e       wrPair,
    input  logic [15:0] wrData,
    input  logic        flagWrEn,
    input  logic [7:0]  flagsIn,
    output logic [7:0]  flags
);

    logic [15:0] pairs [4];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pairs <= '{default: 16'd0};
            flags <= 8'd0;
        end else begin
            if (wrEn) begin
                pairs[wrPair] <= wrData;
            end
            if (flagWrEn) begin
                flags <= flagsIn;
            end
        end
    end

    assign rdData = pairs[rdPair];

endmodule

/* hw/wideAlu.sv */
// 16-bit ADC and SBC with Z80 flag generation
module wideAlu (
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic        carryIn,
    input  logic        subtract,
    output logic [15:0] result,
    output logic [7:0]  flagsOut
);

    logic [15:0] bOp;
    logic        cIn;
    logic [16:0] sum;
    logic [12:0] lowSum;
    logic        overflow;

    // Subtraction as a plus inverted b, with carry in turned into borrow
    assign bOp = subtract ? ~b : b;
    assign cIn = carryIn ^ subtract;

    assign sum = {1'b0, a} + {1'b0, bOp} + {16'd0, cIn};
    assign lowSum = {1'b0, a[11:0]} + {1'b0, bOp[11:0]} + {12'd0, cIn};

    assign result = sum[15:0];
    assign overflow = (a[15] == bOp[15]) && (sum[15] != a[15]);

    // S Z - H - P/V N C
    assign flagsOut = {
        sum[15],
        (sum[15:0] == 16'd0),
        1'b0,
        lowSum[12] ^ subtract,
        1'b0,
        overflow,
        subtract,
        sum[16] ^ subtract
    };

endmodule

/* hw/edDecoder.sv */
// Combinational decoder from opcode to control struct for the 01xxx01x group
module edDecoder import edExecPkg::*; (
    input  opcode_u op,
    output edCtrl_t ctrl
);

    logic inGroup;
    logic isMem;

    // 01xxx01x only
    assign inGroup = (op.xyz.x == 2'd1) && (op.xyz.z[2:1] == 2'b01);

    // z of 3 selects the nn forms
    assign isMem = op.xyz.z[0];

    always_comb begin
        ctrl = '0;
        ctrl.pair = pair_e'(op.xpqz.p);
        if (inGroup) begin
            ctrl.legal = 1'b1;
            if (!isMem) begin
                // SBC HL,rr when q is 0, ADC HL,rr when q is 1
                ctrl.doSbc = ~op.xpqz.q;
                ctrl.doAdc = op.xpqz.q;
                ctrl.writeFlags = 1'b1;
            end else begin
                // LD (nn),rr when q is 0, LD rr,(nn) when q is 1
                ctrl.doStore = ~op.xpqz.q;
                ctrl.doLoad = op.xpqz.q;
                ctrl.needNn = 1'b1;
            end
        end
    end

endmodule

/* hw/edExecPkg.sv */
// Package with the opcode union, pair enum and control, fetch and memory structs
package edExecPkg;

    // Order follows the p field of the opcode
    typedef enum logic [1:0] {
        PairBc,
        PairDe,
        PairHl,
        PairSp
    } pair_e;

    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } opXyz_t;

    typedef struct packed {
        logic [1:0] x;
        logic [1:0] p;
        logic       q;
        logic [2:0] z;
    } opXpqz_t;

    // Same byte, read as x/y/z or as x/p/q/z
    typedef union packed {
        opXyz_t  xyz;
        opXpqz_t xpqz;
    } opcode_u;

    typedef struct packed {
        logic  legal;
        pair_e pair;
        logic  doAdc;
        logic  doSbc;
        logic  doStore;
        logic  doLoad;
        logic  needNn;
        logic  writeFlags;
    } edCtrl_t;

    typedef struct packed {
        logic        badPrefix;
        opcode_u     op;
        logic [15:0] nn;
        logic [15:0] pcNext;
    } fetchRsp_t;

    typedef struct packed {
        logic        req;
        logic        write;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } memReq_t;

    typedef struct packed {
        logic       done;
        logic [7:0] rdata;
    } memRsp_t;

endpackage

/* hw/edExec_defines.svh */
// ED prefix value, reset PC and APB address width
`ifndef ED_EXEC_DEFINES_SVH
`define ED_EXEC_DEFINES_SVH

// First byte of every instruction in the group
`define EdPrefix 8'hED

// Program counter value after reset
`define ResetPc 16'h0000

// Z80 address space is 64 KB
`define ApbAddrWidth 16

`endif
